// ==== include/qpll_drp_params.svh ====
`ifndef QPLL_DRP_PARAMS_SVH
`define QPLL_DRP_PARAMS_SVH

// ------------------------------------------------------------------------
// QPLL DRP register addresses
// ------------------------------------------------------------------------
`define QPLL_ADDR_FBDIV           8'h36
`define QPLL_ADDR_CFG             8'h32
`define QPLL_ADDR_LPF             8'h31
`define QPLL_ADDR_CRSCODE         8'h88
`define QPLL_ADDR_COARSE_OVRD     8'h35
`define QPLL_ADDR_COARSE_OVRD_EN  8'h36
`define QPLL_ADDR_LOCK_CFG        8'h34

// ------------------------------------------------------------------------
// Keep masks, a zero bit is replaced by the write
// ------------------------------------------------------------------------
// Replaces [9:0]
`define QPLL_MASK_FBDIV           16'hFC00
// Replaces [6]
`define QPLL_MASK_CFG             16'hFFBF
// Replaces [14:11]
`define QPLL_MASK_LPF             16'h87FF
// Replaces [15:10]
`define QPLL_MASK_COARSE_OVRD     16'h03FF
// Replaces [11]
`define QPLL_MASK_COARSE_OVRD_EN  16'hF7FF
// Replaces [12:11]
`define QPLL_MASK_LOCK_CFG        16'hE7FF

// ------------------------------------------------------------------------
// Field values for a 100 MHz reference clock
// ------------------------------------------------------------------------
// Feedback divider, N = 100 for Gen1/2 and N = 80 for Gen3
`define QPLL_FBDIV_GEN12          16'h0170
`define QPLL_FBDIV_GEN3           16'h0120

// Band select in bit 6, lower band for Gen3
`define QPLL_CFG_GEN12            16'h0000
`define QPLL_CFG_GEN3             16'h0040

`define QPLL_LPF_GEN12            16'h2000
`define QPLL_LPF_GEN3             16'h6800

// Lock override
`define QPLL_OVRD_EN_NORM         16'h0000
`define QPLL_OVRD_EN_VALUE        16'h0800
`define QPLL_LOCK_CFG_NORM        16'h0000
`define QPLL_LOCK_CFG_OVRD        16'h0000

// ------------------------------------------------------------------------
// Sequencer limits
// ------------------------------------------------------------------------
// Last count of the LOAD wait, LOAD lasts four cycles
`define QPLL_LOAD_CNT_MAX         2'd3
`define QPLL_INDEX_LAST           3'd6
`define QPLL_INDEX_RATE_LAST      3'd2

`endif

// ==== source/qpll_drp_pkg.sv ====
package qpll_drp_pkg;

    // ------------------------------------------------------------------------
    // Sequencer state, one-hot in a single word
    // ------------------------------------------------------------------------
    typedef enum logic [8:0]
    {
        ST_IDLE      = 9'b0_0000_0001,
        ST_LOAD      = 9'b0_0000_0010,
        ST_READ      = 9'b0_0000_0100,
        ST_RRDY      = 9'b0_0000_1000,
        ST_WRITE     = 9'b0_0001_0000,
        ST_WRDY      = 9'b0_0010_0000,
        ST_DONE      = 9'b0_0100_0000,
        ST_QPLLRESET = 9'b0_1000_0000,
        ST_QPLLLOCK  = 9'b1_0000_0000
    } drp_state_t;

    // ------------------------------------------------------------------------
    // Register sequence and DRP words
    // ------------------------------------------------------------------------
    // Position in the register sequence, 0 to 6
    typedef logic [2:0] reg_index_t;

    typedef logic [7:0] drp_addr_t;

    typedef logic [15:0] drp_data_t;

    // Coarse frequency code, read back from bits [6:1] of 0x88
    typedef logic [5:0] crscode_t;

endpackage

// ==== source/drp_input_sync.sv ====
`timescale 1ns/100ps

module drp_input_sync
    import qpll_drp_pkg::*;
(
    input  logic      drp_clk,
    input  logic      drp_rst_n,
    input  logic      drp_ovrd,
    input  logic      drp_gen3,
    input  logic      drp_qplllock,
    input  logic      drp_start,
    input  logic      drp_rdy,
    input  drp_data_t drp_do,
    output logic      ovrd_s,
    output logic      gen3_s,
    output logic      lock_s,
    output logic      start_s,
    output logic      rdy_s,
    output drp_data_t do_s,
    output logic      rate_change
);

    // First stage
    (* ASYNC_REG = "TRUE" *) logic      ovrd_r1;
    (* ASYNC_REG = "TRUE" *) logic      gen3_r1;
    (* ASYNC_REG = "TRUE" *) logic      lock_r1;
    (* ASYNC_REG = "TRUE" *) logic      start_r1;
    (* ASYNC_REG = "TRUE" *) logic      rdy_r1;
    (* ASYNC_REG = "TRUE" *) drp_data_t do_r1;

    // Second stage
    (* ASYNC_REG = "TRUE" *) logic      ovrd_r2;
    (* ASYNC_REG = "TRUE" *) logic      gen3_r2;
    (* ASYNC_REG = "TRUE" *) logic      lock_r2;
    (* ASYNC_REG = "TRUE" *) logic      start_r2;
    (* ASYNC_REG = "TRUE" *) logic      rdy_r2;
    (* ASYNC_REG = "TRUE" *) drp_data_t do_r2;

    // ------------------------------------------------------------------------
    // Control inputs
    // ------------------------------------------------------------------------
    always_ff @(posedge drp_clk)
    begin
        if (!drp_rst_n)
        begin
            {ovrd_r1, gen3_r1, lock_r1, start_r1, rdy_r1} <= '0;
            {ovrd_r2, gen3_r2, lock_r2, start_r2, rdy_r2} <= '0;
        end
        else
        begin
            {ovrd_r1, gen3_r1, lock_r1, start_r1, rdy_r1} <=
                {drp_ovrd, drp_gen3, drp_qplllock, drp_start, drp_rdy};
            {ovrd_r2, gen3_r2, lock_r2, start_r2, rdy_r2} <=
                {ovrd_r1, gen3_r1, lock_r1, start_r1, rdy_r1};
        end
    end

    // Read data, stable before ready reaches the sequencer
    always_ff @(posedge drp_clk)
    begin
        do_r1 <= drp_do;
        do_r2 <= do_r1;
    end

    assign ovrd_s  = ovrd_r2;
    assign gen3_s  = gen3_r2;
    assign lock_s  = lock_r2;
    assign start_s = start_r2;
    assign rdy_s   = rdy_r2;
    assign do_s    = do_r2;

    // Gen3 level about to change on gen3_s
    assign rate_change = gen3_r1 ^ gen3_r2;

    // The rate input is a level, so an edge shows up for a single cycle
    a_rate_change_pulse: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        rate_change |=> !rate_change);

endmodule

// ==== source/qpll_reg_table.sv ====
`timescale 1ns/100ps
`include "qpll_drp_params.svh"

module qpll_reg_table
    import qpll_drp_pkg::*;
(
    input  logic       drp_clk,
    input  logic       drp_rst_n,
    input  reg_index_t index,
    input  logic       mode,
    input  logic       gen3_s,
    input  logic       ovrd_s,
    input  drp_data_t  do_s,
    output drp_addr_t  drp_addr,
    output drp_data_t  drp_di,
    output crscode_t   drp_crscode
);

    drp_data_t fbdiv_val;
    drp_data_t cfg_val;
    drp_data_t lpf_val;
    drp_data_t ovrd_en_val;
    crscode_t  crscode_dec;
    drp_addr_t addr_nxt;
    drp_data_t di_nxt;

    // ------------------------------------------------------------------------
    // Field values
    // ------------------------------------------------------------------------
    // Full sequence always loads the Gen1/2 divider
    assign fbdiv_val = (mode && gen3_s) ? `QPLL_FBDIV_GEN3 : `QPLL_FBDIV_GEN12;
    assign cfg_val   = gen3_s ? `QPLL_CFG_GEN3 : `QPLL_CFG_GEN12;
    assign lpf_val   = gen3_s ? `QPLL_LPF_GEN3 : `QPLL_LPF_GEN12;

    assign ovrd_en_val = ovrd_s ? `QPLL_OVRD_EN_VALUE : `QPLL_OVRD_EN_NORM;

    // Override value sits one step below the read-back code
    assign crscode_dec = drp_crscode - 6'd1;

    // ------------------------------------------------------------------------
    // Address and merged write data per index
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (index)
            3'd0:
            begin
                addr_nxt = `QPLL_ADDR_FBDIV;
                di_nxt   = (do_s & `QPLL_MASK_FBDIV) | fbdiv_val;
            end
            3'd1:
            begin
                addr_nxt = `QPLL_ADDR_CFG;
                di_nxt   = (do_s & `QPLL_MASK_CFG) | cfg_val;
            end
            3'd2:
            begin
                addr_nxt = `QPLL_ADDR_LPF;
                di_nxt   = (do_s & `QPLL_MASK_LPF) | lpf_val;
            end
            3'd3:
            begin
                // Readback only and written back as read
                addr_nxt = `QPLL_ADDR_CRSCODE;
                di_nxt   = do_s;
            end
            3'd4:
            begin
                addr_nxt = `QPLL_ADDR_COARSE_OVRD;
                di_nxt   = (do_s & `QPLL_MASK_COARSE_OVRD) | {crscode_dec, 10'd0};
            end
            3'd5:
            begin
                addr_nxt = `QPLL_ADDR_COARSE_OVRD_EN;
                di_nxt   = (do_s & `QPLL_MASK_COARSE_OVRD_EN) | ovrd_en_val;
            end
            3'd6:
            begin
                addr_nxt = `QPLL_ADDR_LOCK_CFG;
                di_nxt   = (do_s & `QPLL_MASK_LOCK_CFG) | `QPLL_LOCK_CFG_NORM;
            end
            default:
            begin
                addr_nxt = '0;
                di_nxt   = '0;
            end
        endcase
    end

    always_ff @(posedge drp_clk)
    begin
        if (!drp_rst_n)
        begin
            drp_addr    <= '0;
            drp_crscode <= '0;
        end
        else
        begin
            drp_addr <= addr_nxt;
            // Track the 0x88 readback while on index 3
            if ((index == 3'd3) && ovrd_s)
            begin
                drp_crscode <= do_s[6:1];
            end
        end
    end

    always_ff @(posedge drp_clk)
    begin
        drp_di <= di_nxt;
    end

    a_index_range: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        index <= `QPLL_INDEX_LAST);

endmodule

// ==== source/drp_sequencer.sv ====
`timescale 1ns/100ps
`include "qpll_drp_params.svh"

module drp_sequencer
    import qpll_drp_pkg::*;
(
    input  logic       drp_clk,
    input  logic       drp_rst_n,
    input  logic       start_s,
    input  logic       rate_change,
    input  logic       rdy_s,
    input  logic       lock_s,
    output reg_index_t index,
    output logic       mode,
    output logic       drp_en,
    output logic       drp_we,
    output logic       drp_done,
    output logic       drp_qpllreset
);

    drp_state_t state;
    logic [1:0] load_cnt;
    logic       last_index;

    // Rate change stops after the loop filter
    assign last_index = mode ? (index == `QPLL_INDEX_RATE_LAST)
                             : (index == `QPLL_INDEX_LAST);

    // ------------------------------------------------------------------------
    // Load wait
    // ------------------------------------------------------------------------
    // Covers the table register and the read data synchronizer
    always_ff @(posedge drp_clk)
    begin
        if (!drp_rst_n)
        begin
            load_cnt <= 2'd0;
        end
        else if ((state == ST_LOAD) && (load_cnt != `QPLL_LOAD_CNT_MAX))
        begin
            load_cnt <= load_cnt + 2'd1;
        end
        else
        begin
            load_cnt <= 2'd0;
        end
    end

    // ------------------------------------------------------------------------
    // Read-modify-write FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge drp_clk)
    begin
        if (!drp_rst_n)
        begin
            state    <= ST_IDLE;
            index    <= '0;
            mode     <= 1'b0;
            drp_done <= 1'b0;
        end
        else
        begin
            drp_done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    index <= '0;
                    // Start wins over a rate change
                    if (start_s)
                    begin
                        state <= ST_LOAD;
                        mode  <= 1'b0;
                    end
                    else if (rate_change)
                    begin
                        state <= ST_LOAD;
                        mode  <= 1'b1;
                    end
                    else
                    begin
                        mode     <= 1'b0;
                        drp_done <= 1'b1;
                    end
                end
                ST_LOAD:
                begin
                    if (load_cnt == `QPLL_LOAD_CNT_MAX)
                    begin
                        state <= ST_READ;
                    end
                end
                ST_READ:
                begin
                    state <= ST_RRDY;
                end
                ST_RRDY:
                begin
                    if (rdy_s)
                    begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE:
                begin
                    state <= ST_WRDY;
                end
                ST_WRDY:
                begin
                    if (rdy_s)
                    begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE:
                begin
                    if (last_index)
                    begin
                        state <= mode ? ST_QPLLRESET : ST_IDLE;
                        index <= '0;
                    end
                    else
                    begin
                        state <= ST_LOAD;
                        index <= index + 3'd1;
                    end
                end
                // Hold reset until the QPLL drops lock
                ST_QPLLRESET:
                begin
                    if (!lock_s)
                    begin
                        state <= ST_QPLLLOCK;
                    end
                end
                ST_QPLLLOCK:
                begin
                    if (lock_s)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                    index <= '0;
                    mode  <= 1'b0;
                end
            endcase
        end
    end

    assign drp_en        = (state == ST_READ) || (state == ST_WRITE);
    assign drp_we        = (state == ST_WRITE);
    assign drp_qpllreset = (state == ST_QPLLRESET);

    // The slave only answers an access in flight
    a_rdy_when_waiting: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        rdy_s |-> ((state == ST_RRDY) || (state == ST_WRDY)));

    // A rate change pulse is lost unless the sequencer is idle
    a_rate_change_idle: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        rate_change |-> (state == ST_IDLE));

endmodule

// ==== source/qpll_drp_top.sv ====
`timescale 1ns/100ps

module qpll_drp_top
(
    input  logic        drp_clk,
    input  logic        drp_rst_n,
    input  logic        drp_ovrd,
    input  logic        drp_gen3,
    input  logic        drp_qplllock,
    input  logic        drp_start,
    input  logic [15:0] drp_do,
    input  logic        drp_rdy,
    output logic [7:0]  drp_addr,
    output logic        drp_en,
    output logic [15:0] drp_di,
    output logic        drp_we,
    output logic        drp_done,
    output logic        drp_qpllreset,
    output logic [5:0]  drp_crscode
);

    // Synchronized inputs
    logic        ovrd_s;
    logic        gen3_s;
    logic        lock_s;
    logic        start_s;
    logic        rdy_s;
    logic [15:0] do_s;
    logic        rate_change;

    // Sequencer to table
    logic [2:0]  index;
    logic        mode;

    drp_input_sync i_drp_input_sync
    (
        .drp_clk      (drp_clk),
        .drp_rst_n    (drp_rst_n),
        .drp_ovrd     (drp_ovrd),
        .drp_gen3     (drp_gen3),
        .drp_qplllock (drp_qplllock),
        .drp_start    (drp_start),
        .drp_rdy      (drp_rdy),
        .drp_do       (drp_do),
        .ovrd_s       (ovrd_s),
        .gen3_s       (gen3_s),
        .lock_s       (lock_s),
        .start_s      (start_s),
        .rdy_s        (rdy_s),
        .do_s         (do_s),
        .rate_change  (rate_change)
    );

    drp_sequencer i_drp_sequencer
    (
        .drp_clk       (drp_clk),
        .drp_rst_n     (drp_rst_n),
        .start_s       (start_s),
        .rate_change   (rate_change),
        .rdy_s         (rdy_s),
        .lock_s        (lock_s),
        .index         (index),
        .mode          (mode),
        .drp_en        (drp_en),
        .drp_we        (drp_we),
        .drp_done      (drp_done),
        .drp_qpllreset (drp_qpllreset)
    );

    qpll_reg_table i_qpll_reg_table
    (
        .drp_clk     (drp_clk),
        .drp_rst_n   (drp_rst_n),
        .index       (index),
        .mode        (mode),
        .gen3_s      (gen3_s),
        .ovrd_s      (ovrd_s),
        .do_s        (do_s),
        .drp_addr    (drp_addr),
        .drp_di      (drp_di),
        .drp_crscode (drp_crscode)
    );

endmodule

// ==== tb/drp_port_model.sv ====
`timescale 1ns/100ps

module drp_port_model
    import qpll_drp_pkg::*;
(
    input  logic       drp_clk,
    input  drp_addr_t  drp_addr,
    input  logic       drp_en,
    input  drp_data_t  drp_di,
    input  logic       drp_we,
    input  logic       drp_qpllreset,
    input  logic [2:0] rdy_delay,
    output drp_data_t  drp_do,
    output logic       drp_rdy,
    output logic       drp_qplllock
);

    drp_data_t mem [0:255];

    initial
    begin
        drp_do       = '0;
        drp_rdy      = 1'b0;
        drp_qplllock = 1'b1;
    end

    // ------------------------------------------------------------------------
    // DRP slave, one access at a time
    // ------------------------------------------------------------------------
    always @(posedge drp_clk)
    begin
        drp_addr_t  a;
        drp_data_t  d;
        logic       w;
        logic [2:0] dly;
        if (drp_en)
        begin
            a   = drp_addr;
            d   = drp_di;
            w   = drp_we;
            dly = rdy_delay;
            #2;
            if (w)
                mem[a] = d;
            else
                drp_do = mem[a];
            repeat (dly) @(posedge drp_clk);
            #2 drp_rdy = 1'b1;
            @(posedge drp_clk);
            #2 drp_rdy = 1'b0;
        end
    end

    // QPLL drops lock a few cycles into reset, relocks after release
    always @(posedge drp_clk)
    begin
        if (drp_qpllreset)
        begin
            repeat (3) @(posedge drp_clk);
            #2 drp_qplllock = 1'b0;
            while (drp_qpllreset)
                @(posedge drp_clk);
            repeat (10) @(posedge drp_clk);
            #2 drp_qplllock = 1'b1;
        end
    end

endmodule

// ==== tb/tb_qpll_drp.sv ====
`timescale 1ns/100ps
`include "qpll_drp_params.svh"

module tb_qpll_drp
    import qpll_drp_pkg::*;
;

    logic       drp_clk;
    logic       drp_rst_n;
    logic       drp_ovrd;
    logic       drp_gen3;
    logic       drp_start;
    logic       drp_qplllock;
    drp_data_t  drp_do;
    logic       drp_rdy;
    drp_addr_t  drp_addr;
    logic       drp_en;
    drp_data_t  drp_di;
    logic       drp_we;
    logic       drp_done;
    logic       drp_qpllreset;
    crscode_t   drp_crscode;
    logic [2:0] rdy_delay;

    // Reference state
    drp_data_t   image [0:255];
    logic [31:0] seed;
    logic [3:0]  wr_idx;
    logic [3:0]  last_count;
    logic        rate_mode;
    logic        pending;
    crscode_t    ref_crs;
    drp_addr_t   exp_addr;
    drp_data_t   exp_data;
    int          cycle_count;
    int          reset_pulses;

    qpll_drp_top i_qpll_drp_top
    (
        .drp_clk       (drp_clk),
        .drp_rst_n     (drp_rst_n),
        .drp_ovrd      (drp_ovrd),
        .drp_gen3      (drp_gen3),
        .drp_qplllock  (drp_qplllock),
        .drp_start     (drp_start),
        .drp_do        (drp_do),
        .drp_rdy       (drp_rdy),
        .drp_addr      (drp_addr),
        .drp_en        (drp_en),
        .drp_di        (drp_di),
        .drp_we        (drp_we),
        .drp_done      (drp_done),
        .drp_qpllreset (drp_qpllreset),
        .drp_crscode   (drp_crscode)
    );

    drp_port_model i_drp_port_model
    (
        .drp_clk       (drp_clk),
        .drp_addr      (drp_addr),
        .drp_en        (drp_en),
        .drp_di        (drp_di),
        .drp_we        (drp_we),
        .drp_qpllreset (drp_qpllreset),
        .rdy_delay     (rdy_delay),
        .drp_do        (drp_do),
        .drp_rdy       (drp_rdy),
        .drp_qplllock  (drp_qplllock)
    );

    always #20 drp_clk = ~drp_clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Write order of the sequence
    function automatic drp_addr_t addr_for(input logic [3:0] idx);
        case (idx)
            4'd0: return `QPLL_ADDR_FBDIV;
            4'd1: return `QPLL_ADDR_CFG;
            4'd2: return `QPLL_ADDR_LPF;
            4'd3: return `QPLL_ADDR_CRSCODE;
            4'd4: return `QPLL_ADDR_COARSE_OVRD;
            4'd5: return `QPLL_ADDR_COARSE_OVRD_EN;
            default: return `QPLL_ADDR_LOCK_CFG;
        endcase
    endfunction

    function automatic drp_data_t data_for(input logic [3:0] idx, input logic rate,
        input logic gen3, input logic ovrd, input drp_data_t old, input crscode_t crs);
        crscode_t code;
        code = crs - 6'd1;
        case (idx)
            4'd0: return (old & 16'hFC00) | ((rate && gen3) ? 16'h0120 : 16'h0170);
            4'd1: return (old & 16'hFFBF) | (gen3 ? 16'h0040 : 16'h0000);
            4'd2: return (old & 16'h87FF) | (gen3 ? 16'h6800 : 16'h2000);
            4'd3: return old;
            4'd4: return (old & 16'h03FF) | {code, 10'd0};
            4'd5: return (old & 16'hF7FF) | (ovrd ? 16'h0800 : 16'h0000);
            default: return old & 16'hE7FF;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp,
        input logic [15:0] act);
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always_comb
    begin
        exp_addr = addr_for(wr_idx);
        exp_data = data_for(wr_idx, rate_mode, drp_gen3, drp_ovrd, image[exp_addr], ref_crs);
    end

    // ------------------------------------------------------------------------
    // Reference model and bookkeeping
    // ------------------------------------------------------------------------
    always @(posedge drp_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 3000)
            report_failure("Timeout, the sequencer did not finish in 3000 cycles");
        if (drp_en)
        begin
            seed      = lcg_step(seed);
            rdy_delay <= 3'd1 + 3'(seed[31:16] % 6);
        end
        if (drp_en)
            pending <= 1'b1;
        else if (drp_rdy)
            pending <= 1'b0;
        if (drp_en && drp_we)
        begin
            image[drp_addr] <= drp_di;
            if ((wr_idx == 4'd3) && drp_ovrd)
                ref_crs <= image[`QPLL_ADDR_CRSCODE][6:1];
        end
        if (!drp_rst_n || drp_done)
            wr_idx <= '0;
        else if (drp_en && drp_we)
            wr_idx <= wr_idx + 4'd1;
        if (drp_done && (wr_idx != 4'd0))
            last_count <= wr_idx;
        if (drp_rst_n && drp_qpllreset && !$past(drp_qpllreset))
            reset_pulses <= reset_pulses + 1;
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_reset_outputs: assert property (@(posedge drp_clk)
        (!drp_rst_n && cycle_count > 1) |->
        (!drp_en && !drp_we && !drp_qpllreset && drp_crscode == 6'd0))
        else report_failure("Outputs not quiet during reset");

    a_write_addr: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        (drp_en && drp_we) |-> (drp_addr == exp_addr))
        else report_mismatch("write_addr", $sampled(exp_addr), $sampled(drp_addr));

    a_write_data: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        (drp_en && drp_we) |-> (drp_di == exp_data))
        else report_mismatch("write_data", $sampled(exp_data), $sampled(drp_di));

    a_crscode: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        (drp_en && drp_we && wr_idx == 4'd4) |-> (drp_crscode == ref_crs))
        else report_mismatch("crscode", 16'($sampled(ref_crs)), 16'($sampled(drp_crscode)));

    a_en_single: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        drp_en |=> !drp_en)
        else report_failure("DRP enable high for two cycles in a row");

    a_we_only_en: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        drp_we |-> drp_en)
        else report_failure("DRP write enable without enable");

    a_no_overlap: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        drp_en |-> !pending)
        else report_failure("New DRP access before ready of the previous one");

    a_reset_until_unlock: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        (!drp_qpllreset && $past(drp_qpllreset)) |-> !$past(drp_qplllock))
        else report_failure("QPLL reset released before the QPLL lost lock");

    a_done_locked: assert property (@(posedge drp_clk) disable iff (!drp_rst_n)
        drp_done |-> drp_qplllock)
        else report_failure("Done raised while the QPLL is unlocked");

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge drp_clk);
        #2;
    endtask

    task automatic run_full(input logic ovrd);
        drp_ovrd  = ovrd;
        rate_mode = 1'b0;
        repeat (4) next_cycle();
        drp_start = 1'b1;
        while (drp_done)
            next_cycle();
        drp_start = 1'b0;
        while (!drp_done)
            next_cycle();
        // Write count is recorded on the first done cycle
        next_cycle();
        assert (last_count == 4'd7)
            else report_mismatch("full_writes", 16'd7, 16'(last_count));
    endtask

    task automatic run_rate(input logic gen3);
        int pulses;
        pulses    = reset_pulses;
        rate_mode = 1'b1;
        drp_gen3  = gen3;
        while (drp_done)
            next_cycle();
        while (!drp_done)
            next_cycle();
        // Write count is recorded on the first done cycle
        next_cycle();
        assert (last_count == 4'd3)
            else report_mismatch("rate_writes", 16'd3, 16'(last_count));
        assert (reset_pulses == pulses + 1)
            else report_failure("No QPLL reset pulse after a rate change");
    endtask

    initial
    begin
        drp_clk      = 1'b0;
        drp_rst_n    = 1'b0;
        drp_ovrd     = 1'b0;
        drp_gen3     = 1'b0;
        drp_start    = 1'b0;
        rdy_delay    = 3'd1;
        seed         = 32'h952d_b94b;
        pending      = 1'b0;
        ref_crs      = '0;
        rate_mode    = 1'b0;
        last_count   = '0;
        cycle_count  = 0;
        reset_pulses = 0;
        for (int a = 0; a < 256; a++)
        begin
            seed = lcg_step(seed);
            image[a] = seed[31:16];
            i_drp_port_model.mem[a] = seed[31:16];
        end
        repeat (5) next_cycle();
        drp_rst_n = 1'b1;
        repeat (3) next_cycle();
        assert (drp_done)
            else report_failure("Done not high while idle after reset");

        run_full(1'b0);
        run_full(1'b1);
        run_rate(1'b1);
        run_full(1'b0);
        run_full(1'b1);
        run_rate(1'b0);
        repeat (5) next_cycle();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
source/qpll_drp_pkg.sv
source/drp_input_sync.sv
source/qpll_reg_table.sv
source/drp_sequencer.sv
source/qpll_drp_top.sv
tb/drp_port_model.sv
tb/tb_qpll_drp.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_qpll_drp
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
